// ==== rtl/bus_master.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory-side bus master that writes FIFO words one at a time
// Raises done once the SCSI side has finished and everything is written
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module bus_master import sdmac_pkg::*; (
  input  logic              sclk,
  input  logic              rst_n,
  input  logic              start,
  input  logic [ADDR_W-1:0] start_addr,
  input  logic              fifo_empty,
  input  logic [DATA_W-1:0] fifo_rdata,
  input  logic              mem_ack_n,
  input  logic              sm_finished,
  output logic              fifo_pop,
  output logic              mem_as_n,
  output logic [ADDR_W-1:0] mem_addr,
  output logic [DATA_W-1:0] mem_wdata,
  output logic              done
);

  logic              busy_q;
  logic              ack_seen;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] data_q;

  // A new word is taken only between bus cycles
  assign fifo_pop = !busy_q && !fifo_empty;
  assign ack_seen = busy_q && !mem_ack_n;

  always_ff @(posedge sclk) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      done   <= 1'b0;
    end else begin
      if (fifo_pop) begin
        busy_q <= 1'b1;
      end else if (ack_seen) begin
        busy_q <= 1'b0;
      end
      if (start) begin
        done <= 1'b0;
      end else if (sm_finished && fifo_empty && !busy_q) begin
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge sclk) begin
    if (start) begin
      addr_q <= start_addr;
    end else if (ack_seen) begin
      addr_q <= addr_q + ADDR_W'(BYTES_PER_WORD);
    end
    if (fifo_pop) begin
      data_q <= fifo_rdata;
    end
  end

  assign mem_as_n  = ~busy_q;
  assign mem_addr  = addr_q;
  assign mem_wdata = data_q;

  a_bus_stable: assert property (@(posedge sclk) disable iff (!rst_n)
    !mem_as_n |=> mem_as_n || ($stable(mem_addr) && $stable(mem_wdata)))
    else $error("bus_master: address or data moved during a bus cycle");

endmodule

// ==== rtl/dma_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Show-ahead word FIFO between the SCSI side and the bus master
// rdata always presents the oldest entry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module dma_fifo import sdmac_pkg::*; (
  input  logic              sclk,
  input  logic              rst_n,
  input  logic              push,
  input  logic [DATA_W-1:0] wdata,
  input  logic              pop,
  output logic [DATA_W-1:0] rdata,
  output logic              full,
  output logic              empty
);

  logic [DATA_W-1:0]  mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr_q;
  logic [FIFO_AW-1:0] rd_ptr_q;
  logic [FIFO_AW:0]   count_q;
  logic [FIFO_AW:0]   count_d;

  always_comb begin
    count_d = count_q;
    if (push && !pop) begin
      count_d = count_q + 1'b1;
    end else if (pop && !push) begin
      count_d = count_q - 1'b1;
    end
  end

  // Flags come from the next count so they are valid right after the edge
  always_ff @(posedge sclk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      full     <= 1'b0;
      empty    <= 1'b1;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_d;
      full    <= (count_d == (FIFO_AW+1)'(FIFO_DEPTH));
      empty   <= (count_d == '0);
    end
  end

  always_ff @(posedge sclk) begin
    if (push) begin
      mem[wr_ptr_q] <= wdata;
    end
  end

  assign rdata = mem[rd_ptr_q];

  a_no_push_full: assert property (@(posedge sclk) disable iff (!rst_n)
    push |-> !full) else $error("dma_fifo: push while full");
  a_no_pop_empty: assert property (@(posedge sclk) disable iff (!rst_n)
    pop |-> !empty) else $error("dma_fifo: pop while empty");

endmodule

// ==== rtl/scsi_dma_sm.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SCSI side of the DMA path: byte handshake, packing and FIFO push
// Next state is built from the decoder's product terms
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module scsi_dma_sm import sdmac_pkg::*; (
  input  logic               sclk,
  input  logic               rst_n,
  input  logic               start,
  input  logic [COUNT_W-1:0] xfer_words,
  input  logic               dreq_n,
  input  logic [BYTE_W-1:0]  sdata,
  input  logic               fifo_full,
  output logic               dack_n,
  output logic               fifo_push,
  output logic [DATA_W-1:0]  fifo_wdata,
  output logic               sm_finished
);

  scsi_state_t                         state_q;
  scsi_state_t                         state_d;
  logic [4:0]                          nxt;
  logic [$clog2(BYTES_PER_WORD)-1:0]   bo_q;
  logic [COUNT_W-1:0]                  cnt_q;
  logic [DATA_W-1:0]                   word_q;
  logic                                boeq3;
  logic                                last_word;
  logic [NUM_TERMS-1:0]                term_n;

  assign boeq3     = &bo_q;
  assign last_word = (cnt_q == COUNT_W'(1));

  scsi_term_decode u_term_decode (
    .state_q   (state_q),
    .dreq_n    (dreq_n),
    .boeq3     (boeq3),
    .fifo_full (fifo_full),
    .last_word (last_word),
    .start     (start),
    .term_n    (term_n)
  );

  // Each state flop is set by the OR of the terms that enter it.
  // Idle holds itself until start; done holds because no term sets a bit
  assign nxt[0] = state_q[0] & term_n[0];
  assign nxt[1] = ~term_n[0] | ~term_n[2] | ~term_n[5] | ~term_n[8] | ~term_n[9];
  assign nxt[2] = ~term_n[1];
  assign nxt[3] = ~term_n[3];
  assign nxt[4] = ~term_n[4] | ~term_n[6];
  assign state_d = scsi_state_t'(nxt);

  always_ff @(posedge sclk) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      bo_q    <= '0;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (!term_n[0] || !term_n[9]) begin
        bo_q  <= '0;
        cnt_q <= xfer_words;
      end
      // Offset wraps to lane 0 after the fourth byte
      if (!term_n[4] || !term_n[5]) begin
        bo_q <= bo_q + 1'b1;
      end
      if (!term_n[8]) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Byte is taken on the edge that ends the dack_n pulse
  always_ff @(posedge sclk) begin
    if (!term_n[3]) begin
      word_q[bo_q*BYTE_W +: BYTE_W] <= sdata;
    end
  end

  assign dack_n      = term_n[3];
  assign fifo_push   = ~(term_n[7] & term_n[8]);
  assign fifo_wdata  = word_q;
  assign sm_finished = (state_q == S_DONE);

  // A strobe is always followed by the pack cycle
  a_dack_single: assert property (@(posedge sclk) disable iff (!rst_n)
    !dack_n |=> dack_n)
    else $error("scsi_dma_sm: dack_n low for two cycles");

endmodule

// ==== rtl/scsi_term_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Product-term decoder for the SCSI side state machine
// Turns state flops and qualifiers into active-low transition terms
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module scsi_term_decode import sdmac_pkg::*; (
  input  scsi_state_t           state_q,
  input  logic                  dreq_n,
  input  logic                  boeq3,
  input  logic                  fifo_full,
  input  logic                  last_word,
  input  logic                  start,
  output logic [NUM_TERMS-1:0]  term_n
);

  logic q_idle;
  logic q_wait;
  logic q_ack;
  logic q_pack;
  logic q_push;
  logic n_q_idle;
  logic n_q_wait;
  logic n_q_ack;
  logic n_q_pack;
  logic n_q_push;
  logic n_dreq_n;
  logic n_fifo_full;

  // State flops, one per active state
  assign q_idle = state_q[0];
  assign q_wait = state_q[1];
  assign q_ack  = state_q[2];
  assign q_pack = state_q[3];
  assign q_push = state_q[4];

  assign n_q_idle    = ~q_idle;
  assign n_q_wait    = ~q_wait;
  assign n_q_ack     = ~q_ack;
  assign n_q_pack    = ~q_pack;
  assign n_q_push    = ~q_push;
  assign n_dreq_n    = ~dreq_n;
  assign n_fifo_full = ~fifo_full;

  // Term map
  //   0 idle and start          5 pack, more bytes to come
  //   1 wait, request present   6 push, FIFO full
  //   2 wait, no request        7 push, room, last word
  //   3 ack                     8 push, room, more words
  //   4 pack, byte offset 3     9 done and start
  assign term_n[0] = ~(q_idle & start);
  assign term_n[1] = ~(q_wait & n_dreq_n);
  assign term_n[2] = ~(q_wait & dreq_n);
  assign term_n[3] = ~(q_ack);
  assign term_n[4] = ~(q_pack & boeq3);
  assign term_n[5] = ~(q_pack & ~boeq3);
  assign term_n[6] = ~(q_push & fifo_full);
  assign term_n[7] = ~(q_push & n_fifo_full & last_word);
  assign term_n[8] = ~(q_push & n_fifo_full & ~last_word);
  // Done is the only state with every flop clear
  assign term_n[9] = ~(n_q_idle & n_q_wait & n_q_ack & n_q_pack & n_q_push & start);

  // Holds only while the state register carries a legal one-hot or zero code
  always_comb begin
    assert ($isunknown(term_n) || $onehot0(~term_n))
      else $error("scsi_term_decode: more than one term active");
  end

endmodule

// ==== rtl/sdmac_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes and the SCSI state encoding shared by the DMA path
// Imported by each RTL module and the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package sdmac_pkg;

  // Memory side word and SCSI side byte
  localparam int DATA_W         = 32;
  localparam int BYTE_W         = 8;
  localparam int BYTES_PER_WORD = 4;

  // Word FIFO between the SCSI side and the bus master
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = 3;

  // Host programming
  localparam int COUNT_W = 8;
  localparam int ADDR_W  = 32;

  // Product terms produced by the term decoder
  localparam int NUM_TERMS = 10;

  // One flop per active state, so the decoder can test a single bit.
  // S_DONE is the all-zero pattern; any pattern with more than one
  // bit set is reserved and never reached from reset
  typedef enum logic [4:0] {
    S_DONE     = 5'b00000,
    S_IDLE     = 5'b00001,
    S_WAIT_REQ = 5'b00010,
    S_ACK      = 5'b00100,
    S_PACK     = 5'b01000,
    S_PUSH     = 5'b10000
  } scsi_state_t;

endpackage

// ==== rtl/sdmac_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SCSI-to-memory DMA path: SCSI state machine, word FIFO, bus master
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module sdmac_top import sdmac_pkg::*; (
  input  logic               sclk,
  input  logic               rst_n,
  input  logic               start,
  input  logic [ADDR_W-1:0]  start_addr,
  input  logic [COUNT_W-1:0] xfer_words,
  input  logic               dreq_n,
  input  logic [BYTE_W-1:0]  sdata,
  output logic               dack_n,
  output logic               mem_as_n,
  output logic [ADDR_W-1:0]  mem_addr,
  output logic [DATA_W-1:0]  mem_wdata,
  input  logic               mem_ack_n,
  output logic               done
);

  logic              fifo_push;
  logic [DATA_W-1:0] fifo_wdata;
  logic              fifo_full;
  logic              fifo_pop;
  logic [DATA_W-1:0] fifo_rdata;
  logic              fifo_empty;
  logic              sm_finished;

  scsi_dma_sm u_scsi_sm (
    .sclk        (sclk),
    .rst_n       (rst_n),
    .start       (start),
    .xfer_words  (xfer_words),
    .dreq_n      (dreq_n),
    .sdata       (sdata),
    .fifo_full   (fifo_full),
    .dack_n      (dack_n),
    .fifo_push   (fifo_push),
    .fifo_wdata  (fifo_wdata),
    .sm_finished (sm_finished)
  );

  dma_fifo u_fifo (
    .sclk  (sclk),
    .rst_n (rst_n),
    .push  (fifo_push),
    .wdata (fifo_wdata),
    .pop   (fifo_pop),
    .rdata (fifo_rdata),
    .full  (fifo_full),
    .empty (fifo_empty)
  );

  bus_master u_bus_master (
    .sclk        (sclk),
    .rst_n       (rst_n),
    .start       (start),
    .start_addr  (start_addr),
    .fifo_empty  (fifo_empty),
    .fifo_rdata  (fifo_rdata),
    .mem_ack_n   (mem_ack_n),
    .sm_finished (sm_finished),
    .fifo_pop    (fifo_pop),
    .mem_as_n    (mem_as_n),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .done        (done)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compiles the DMA testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f tb.f --top-module tb_sdmac -o tb_sdmac \
  && ./obj_dir/tb_sdmac > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^all tests passed$" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== sim/tb_sdmac.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the SCSI DMA path with random device and memory models
// Built and run by run_sim.sh; ends with an error count and a verdict
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_sdmac import sdmac_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_XFERS = 6;
  localparam int FILL_IDX  = 1;

  logic               sclk = 1'b0;
  logic               rst_n;
  logic               start;
  logic [ADDR_W-1:0]  start_addr;
  logic [COUNT_W-1:0] xfer_words;
  logic               dreq_n;
  logic [BYTE_W-1:0]  sdata;
  logic               dack_n;
  logic               mem_as_n;
  logic [ADDR_W-1:0]  mem_addr;
  logic [DATA_W-1:0]  mem_wdata;
  logic               mem_ack_n;
  logic               done;

  integer             seed = 32'h661e;
  int                 errors = 0;
  int                 checks = 0;
  int                 timeout_cycles = 0;
  int                 writes_seen = 0;
  int                 dacks_seen = 0;
  int                 max_backlog = 0;
  int                 mem_min = 0;
  int                 mem_span = 13;
  logic [BYTE_W-1:0]  byte_q[$];
  logic [ADDR_W-1:0]  addrs [NUM_XFERS];
  logic [COUNT_W-1:0] counts [NUM_XFERS];
  logic [ADDR_W-1:0]  exp_addr;

  sdmac_top DUT (
    .sclk       (sclk),
    .rst_n      (rst_n),
    .start      (start),
    .start_addr (start_addr),
    .xfer_words (xfer_words),
    .dreq_n     (dreq_n),
    .sdata      (sdata),
    .dack_n     (dack_n),
    .mem_as_n   (mem_as_n),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_ack_n  (mem_ack_n),
    .done       (done)
  );

  always #10 sclk = ~sclk;

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // Reference word puts the first device byte of the word in the lowest lane
  task automatic compare_write();
    logic [DATA_W-1:0] exp_data;
    int i;
    if (byte_q.size() < BYTES_PER_WORD) begin
      errors++;
      $display("Memory write to %h came before four device bytes were taken", mem_addr);
    end else begin
      exp_data = '0;
      for (i = 0; i < BYTES_PER_WORD; i++) begin
        exp_data[i*BYTE_W +: BYTE_W] = byte_q.pop_front();
      end
      check("write_data", exp_data, mem_wdata);
    end
    check("write_addr", exp_addr, mem_addr);
    check("write_after_done", 32'd0, 32'(done));
    exp_addr = exp_addr + ADDR_W'(BYTES_PER_WORD);
    writes_seen++;
  endtask

  // SCSI device model holds each byte with dreq_n low until it sees dack_n
  initial begin : device_model
    int gap;
    logic [BYTE_W-1:0] b;
    @(posedge rst_n);
    forever begin
      gap = int'($unsigned($random(seed)) % 6);
      repeat (gap) begin
        @(posedge sclk);
        #2;
      end
      b = BYTE_W'($random(seed));
      sdata = b;
      dreq_n = 1'b0;
      @(negedge sclk);
      while (dack_n !== 1'b0) @(negedge sclk);
      @(posedge sclk);
      #2;
      dreq_n = 1'b1;
      byte_q.push_back(b);
    end
  end

  // Memory model gives one acknowledge pulse per strobe after a random wait
  initial begin : memory_model
    int delay;
    forever begin
      @(negedge sclk);
      if (rst_n === 1'b1 && mem_as_n === 1'b0) begin
        compare_write();
        delay = mem_min + int'($unsigned($random(seed)) % mem_span);
        repeat (delay) @(posedge sclk);
        @(posedge sclk);
        #2 mem_ack_n = 1'b0;
        @(posedge sclk);
        #2 mem_ack_n = 1'b1;
      end
    end
  end

  always @(negedge sclk) begin
    if (rst_n === 1'b1 && dack_n === 1'b0) begin
      dacks_seen++;
      check("dreq_at_dack", 32'd0, 32'(dreq_n));
    end
  end

  // Words fully taken from the device but not yet seen on the memory bus
  always @(posedge sclk) begin
    if (dacks_seen / BYTES_PER_WORD - writes_seen > max_backlog) begin
      max_backlog = dacks_seen / BYTES_PER_WORD - writes_seen;
    end
  end

  initial begin : watchdog
    scsi_state_t st;
    wait (timeout_cycles > 0);
    repeat (timeout_cycles) @(posedge sclk);
    st = DUT.u_scsi_sm.state_q;
    $display("Timeout: transfers did not finish within %0d cycles, SCSI state %s",
             timeout_cycles, st.name());
    $display("tests failed");
    $finish;
  end

  task automatic run_transfer(input int idx);
    // Slow memory on one transfer backs the FIFO up into the SCSI side
    if (idx == FILL_IDX) begin
      mem_min  = 30;
      mem_span = 16;
    end else begin
      mem_min  = 0;
      mem_span = 13;
    end
    @(posedge sclk);
    #2;
    start       = 1'b1;
    start_addr  = addrs[idx];
    xfer_words  = counts[idx];
    exp_addr    = addrs[idx];
    writes_seen = 0;
    dacks_seen  = 0;
    max_backlog = 0;
    @(posedge sclk);
    #2;
    start = 1'b0;
    @(negedge sclk);
    check("done_cleared", 32'd0, 32'(done));
    while (done !== 1'b1) @(negedge sclk);
    repeat (10) @(negedge sclk);
    check("word_count", 32'(counts[idx]), 32'(writes_seen));
    check("dack_count", 32'(counts[idx]) * BYTES_PER_WORD, 32'(dacks_seen));
    check("bytes_left", 32'd0, 32'(byte_q.size()));
    if (idx == FILL_IDX) begin
      check("fifo_backlog", 32'd1, 32'(max_backlog >= FIFO_DEPTH));
    end
  endtask

  initial begin : stimulus
    int i;
    int budget;
    rst_n      = 1'b0;
    start      = 1'b0;
    start_addr = '0;
    xfer_words = '0;
    dreq_n     = 1'b1;
    sdata      = '0;
    mem_ack_n  = 1'b1;
    budget     = 1000;
    for (i = 0; i < NUM_XFERS; i++) begin
      counts[i] = COUNT_W'(1 + $unsigned($random(seed)) % 40);
      addrs[i]  = ADDR_W'($random(seed)) & ~ADDR_W'(3);
    end
    counts[FILL_IDX] = COUNT_W'(40);
    for (i = 0; i < NUM_XFERS; i++) begin
      budget = budget + int'(counts[i]) * BYTES_PER_WORD * 20;
    end
    timeout_cycles = budget;
    repeat (3) @(posedge sclk);
    #2 rst_n = 1'b1;
    @(negedge sclk);
    check("reset_dack_n", 32'd1, 32'(dack_n));
    check("reset_mem_as_n", 32'd1, 32'(mem_as_n));
    check("reset_done", 32'd0, 32'(done));
    for (i = 0; i < NUM_XFERS; i++) begin
      run_transfer(i);
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
rtl/sdmac_pkg.sv
rtl/scsi_term_decode.sv
rtl/scsi_dma_sm.sv
rtl/dma_fifo.sv
rtl/bus_master.sv
rtl/sdmac_top.sv
sim/tb_sdmac.sv
